//--- all.f
+incdir+src
+incdir+verification
src/muldiv_pkg.sv
src/mul_unit.sv
src/div_unit.sv
src/muldiv_exe.sv
src/phys_regfile.sv
src/muldiv_top.sv
verification/tb_muldiv_top.sv

//--- build.sh
#!/bin/sh
# Build the multiply/divide testbench with Verilator and run it.
# Exit status is 0 only when the simulation log holds the pass message.

cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --assert -j 0 --top-module tb_muldiv_top -f all.f -o sim_tb > "$BUILD_LOG" 2>&1
status=$?
if [ $status -ne 0 ]; then
	cat "$BUILD_LOG"
	echo "verilator build failed with status $status"
	exit 1
fi

./obj_dir/sim_tb > "$SIM_LOG" 2>&1
status=$?
cat "$SIM_LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q '^\*\* PASS \*\*$' "$SIM_LOG"; then
	exit 0
fi
echo "pass message not found in $SIM_LOG"
exit 1

//--- verification/muldiv_model.svh
/*
 * reference model of the RV64M operations
 *   expected result of each opcode, truncating division
 *   divide-by-zero and overflow results, W sign extension
 *   check for single-cycle writeback
 */

`ifndef MULDIV_MODEL_SVH
`define MULDIV_MODEL_SVH

function automatic logic [`XLEN-1:0] sext32(input logic [31:0] v);
	return {{(`XLEN-32){v[31]}}, v};
endfunction

function automatic logic [`XLEN-1:0] expect_result(input muldiv_pkg::muldiv_op_e op,
		input logic [`XLEN-1:0] a, input logic [`XLEN-1:0] b);
	logic [2*`XLEN-1:0] p;
	logic signed [`XLEN-1:0] sa;
	logic signed [`XLEN-1:0] sb;
	logic signed [`XLEN-1:0] q;
	logic signed [31:0] wa;
	logic signed [31:0] wb;
	logic ovf;
	logic ovf_w;
	sa = a;
	sb = b;
	wa = a[31:0];
	wb = b[31:0];
	ovf = (a == {1'b1, {(`XLEN-1){1'b0}}}) && (b == '1);  // min / -1
	ovf_w = (a[31:0] == 32'h8000_0000) && (b[31:0] == '1);
	p = '0;
	case (op)
		muldiv_pkg::op_mul: return a * b;
		muldiv_pkg::op_mulh: p = {{`XLEN{a[`XLEN-1]}}, a} * {{`XLEN{b[`XLEN-1]}}, b};
		muldiv_pkg::op_mulhsu: p = {{`XLEN{a[`XLEN-1]}}, a} * {{`XLEN{1'b0}}, b};
		muldiv_pkg::op_mulhu: p = {{`XLEN{1'b0}}, a} * {{`XLEN{1'b0}}, b};
		muldiv_pkg::op_mulw: return sext32(a[31:0] * b[31:0]);
		muldiv_pkg::op_div: begin
			if (b == '0)
				return '1;
			if (ovf)
				return a;
			q = sa / sb;  // signed, truncates toward zero
			return q;
		end
		muldiv_pkg::op_rem: begin
			if (b == '0)
				return a;
			if (ovf)
				return '0;
			q = sa % sb;  // sign of the dividend
			return q;
		end
		muldiv_pkg::op_divu: return (b == '0) ? '1 : a / b;
		muldiv_pkg::op_remu: return (b == '0) ? a : a % b;
		muldiv_pkg::op_divw: return (wb == '0) ? '1 : (ovf_w ? sext32(a[31:0]) : sext32(wa / wb));
		muldiv_pkg::op_remw: return (wb == '0) ? sext32(a[31:0]) : (ovf_w ? '0 : sext32(wa % wb));
		muldiv_pkg::op_divuw: return (wb == '0) ? '1 : sext32(a[31:0] / b[31:0]);
		muldiv_pkg::op_remuw: return (wb == '0) ? sext32(a[31:0]) : sext32(a[31:0] % b[31:0]);
		default: return '0;
	endcase
	return p[2*`XLEN-1:`XLEN];  // high half for the MULH forms
endfunction

// multiplies and divide special cases write back one cycle after issue
function automatic bit expect_short(input muldiv_pkg::muldiv_op_e op,
		input logic [`XLEN-1:0] a, input logic [`XLEN-1:0] b);
	case (op)
		muldiv_pkg::op_div, muldiv_pkg::op_rem:
			return (b == '0) || ((a == {1'b1, {(`XLEN-1){1'b0}}}) && (b == '1));
		muldiv_pkg::op_divu, muldiv_pkg::op_remu:
			return b == '0;
		muldiv_pkg::op_divw, muldiv_pkg::op_remw:
			return (b[31:0] == '0) || ((a[31:0] == 32'h8000_0000) && (b[31:0] == '1));
		muldiv_pkg::op_divuw, muldiv_pkg::op_remuw:
			return b[31:0] == '0;
		default:
			return 1'b1;
	endcase
endfunction

`endif

//--- verification/tb_muldiv_top.sv
/*
 * tb_muldiv_top
 *   clock, reset and DUT instance
 *   stimulus table of RV64M operations applied in a loop
 *   flush, register chaining and back-to-back multiplies
 *   per-test lines and closing summary
 */

`timescale 1ns/10ps
`include "muldiv_defines.svh"

module tb_muldiv_top;

	`include "muldiv_model.svh"

	localparam int wb_timeout = 100;
	localparam int ready_timeout = 100;
	localparam int flush_watch = 70;
	localparam logic [`XLEN-1:0] ones = '1;
	localparam logic [`XLEN-1:0] min_v = {1'b1, {(`XLEN-1){1'b0}}};

	logic CLK;
	logic rst;
	logic flush;
	logic load_en;
	logic [`REG_IDX_W-1:0] load_idx;
	logic [`XLEN-1:0] load_data;
	logic issue_valid;
	muldiv_pkg::muldiv_op_e issue_op;
	logic [`REG_IDX_W-1:0] issue_rd;
	logic [`REG_IDX_W-1:0] issue_rs1;
	logic [`REG_IDX_W-1:0] issue_rs2;
	logic issue_ready;
	logic wb_valid;
	logic [`REG_IDX_W-1:0] wb_rd;
	logic [`XLEN-1:0] wb_data;

	// stimulus table, one entry per row in every queue
	muldiv_pkg::muldiv_op_e row_op[$];
	int row_rd[$];
	int row_rs1[$];
	int row_rs2[$];
	logic [`XLEN-1:0] row_v1[$];
	logic [`XLEN-1:0] row_v2[$];
	int row_rnd[$];  // nonzero: random operands
	int row_flush[$];  // nonzero: flush after that many cycles
	int row_chain[$];  // nonzero: rs1 is the previous row's rd

	int n_tests;
	int n_errors;
	int prev_rd;
	logic [`XLEN-1:0] prev_val;

	muldiv_top dut (
		.CLK         (CLK),
		.rst         (rst),
		.flush       (flush),
		.load_en     (load_en),
		.load_idx    (load_idx),
		.load_data   (load_data),
		.issue_valid (issue_valid),
		.issue_op    (issue_op),
		.issue_rd    (issue_rd),
		.issue_rs1   (issue_rs1),
		.issue_rs2   (issue_rs2),
		.issue_ready (issue_ready),
		.wb_valid    (wb_valid),
		.wb_rd       (wb_rd),
		.wb_data     (wb_data)
	);

	initial begin
		CLK = 1'b0;
		forever #4 CLK = ~CLK;
	end

	task automatic tick();
		@(posedge CLK);
		#1;  // drive and sample just after the edge
	endtask

	task automatic check_val(input string name, input logic [`XLEN-1:0] exp,
			input logic [`XLEN-1:0] got);
		assert (got === exp) else begin
			$display("ERR %0t %s exp %h got %h", $time, name, exp, got);
			n_errors++;
		end
	endtask

	task automatic add_row(input muldiv_pkg::muldiv_op_e op, input int rd, input int rs1,
			input int rs2, input logic [`XLEN-1:0] v1, input logic [`XLEN-1:0] v2,
			input int rnd, input int flush_n, input int chain);
		row_op.push_back(op);
		row_rd.push_back(rd);
		row_rs1.push_back(rs1);
		row_rs2.push_back(rs2);
		row_v1.push_back(v1);
		row_v2.push_back(v2);
		row_rnd.push_back(rnd);
		row_flush.push_back(flush_n);
		row_chain.push_back(chain);
	endtask

	task automatic build_table();
		// multiply family, corners then random
		add_row(muldiv_pkg::op_mul, 3, 1, 2, 64'd7, -64'sd3, 0, 0, 0);
		add_row(muldiv_pkg::op_mul, 3, 1, 2, min_v, ones, 0, 0, 0);
		add_row(muldiv_pkg::op_mulh, 3, 1, 2, min_v, min_v, 0, 0, 0);
		add_row(muldiv_pkg::op_mulh, 3, 1, 2, ones, ones, 0, 0, 0);
		add_row(muldiv_pkg::op_mulh, 3, 1, 2, min_v, 64'd1, 0, 0, 0);
		add_row(muldiv_pkg::op_mulhsu, 3, 1, 2, ones, ones, 0, 0, 0);
		add_row(muldiv_pkg::op_mulhsu, 3, 1, 2, min_v, 64'd2, 0, 0, 0);
		add_row(muldiv_pkg::op_mulhu, 3, 1, 2, ones, ones, 0, 0, 0);
		add_row(muldiv_pkg::op_mulhu, 3, 1, 2, min_v, 64'd1, 0, 0, 0);
		add_row(muldiv_pkg::op_mul, 3, 1, 2, '0, '0, 1, 0, 0);
		add_row(muldiv_pkg::op_mulh, 3, 1, 2, '0, '0, 1, 0, 0);
		add_row(muldiv_pkg::op_mulhsu, 3, 1, 2, '0, '0, 1, 0, 0);
		add_row(muldiv_pkg::op_mulhu, 3, 1, 2, '0, '0, 1, 0, 0);
		// divide and remainder, all four sign combinations
		add_row(muldiv_pkg::op_div, 4, 1, 2, 64'd100, 64'd7, 0, 0, 0);
		add_row(muldiv_pkg::op_div, 4, 1, 2, -64'sd100, 64'd7, 0, 0, 0);
		add_row(muldiv_pkg::op_div, 4, 1, 2, 64'd100, -64'sd7, 0, 0, 0);
		add_row(muldiv_pkg::op_div, 4, 1, 2, -64'sd100, -64'sd7, 0, 0, 0);
		add_row(muldiv_pkg::op_rem, 4, 1, 2, 64'd100, 64'd7, 0, 0, 0);
		add_row(muldiv_pkg::op_rem, 4, 1, 2, -64'sd100, 64'd7, 0, 0, 0);
		add_row(muldiv_pkg::op_rem, 4, 1, 2, 64'd100, -64'sd7, 0, 0, 0);
		add_row(muldiv_pkg::op_rem, 4, 1, 2, -64'sd100, -64'sd7, 0, 0, 0);
		add_row(muldiv_pkg::op_divu, 4, 1, 2, ones, 64'd7, 0, 0, 0);
		add_row(muldiv_pkg::op_remu, 4, 1, 2, ones, 64'd7, 0, 0, 0);
		add_row(muldiv_pkg::op_div, 4, 1, 2, '0, '0, 1, 0, 0);
		add_row(muldiv_pkg::op_remu, 4, 1, 2, '0, '0, 1, 0, 0);
		// divide by zero and signed overflow
		add_row(muldiv_pkg::op_div, 5, 1, 2, -64'sd5, '0, 0, 0, 0);
		add_row(muldiv_pkg::op_rem, 5, 1, 2, -64'sd5, '0, 0, 0, 0);
		add_row(muldiv_pkg::op_divu, 5, 1, 2, 64'd9, '0, 0, 0, 0);
		add_row(muldiv_pkg::op_remu, 5, 1, 2, 64'd9, '0, 0, 0, 0);
		add_row(muldiv_pkg::op_div, 5, 1, 2, min_v, ones, 0, 0, 0);
		add_row(muldiv_pkg::op_rem, 5, 1, 2, min_v, ones, 0, 0, 0);
		// W forms, upper operand bits are ignored
		add_row(muldiv_pkg::op_mulw, 6, 1, 2, 64'hdead_beef_1234_5678, 64'h1_9abc_def0, 0, 0, 0);
		add_row(muldiv_pkg::op_mulw, 6, 1, 2, 64'h8000_0000, ones, 0, 0, 0);
		add_row(muldiv_pkg::op_divw, 6, 1, 2, 64'hffff_0000_8000_0000, 64'h1234_5678_ffff_ffff,
			0, 0, 0);
		add_row(muldiv_pkg::op_remw, 6, 1, 2, 64'hffff_0000_8000_0000, 64'h1234_5678_ffff_ffff,
			0, 0, 0);
		add_row(muldiv_pkg::op_divw, 6, 1, 2, 64'h1_0000_0064, 64'h7777_7777_ffff_fff9, 0, 0, 0);
		add_row(muldiv_pkg::op_divw, 6, 1, 2, 64'd100, 64'h5555_5555_0000_0000, 0, 0, 0);
		add_row(muldiv_pkg::op_remw, 6, 1, 2, 64'h1111_1111_8000_0005, 64'h3_0000_0000, 0, 0, 0);
		add_row(muldiv_pkg::op_divuw, 6, 1, 2, 64'hffff_ffff_ffff_fff0, 64'd3, 0, 0, 0);
		add_row(muldiv_pkg::op_divuw, 6, 1, 2, 64'hffff_ffff, 64'd1, 0, 0, 0);
		add_row(muldiv_pkg::op_divuw, 6, 1, 2, 64'd17, 64'h9_0000_0000, 0, 0, 0);
		add_row(muldiv_pkg::op_remuw, 6, 1, 2, 64'h1234_5678_ffff_fffe, 64'd7, 0, 0, 0);
		add_row(muldiv_pkg::op_remuw, 6, 1, 2, 64'h8000_0000, '0, 0, 0, 0);
		add_row(muldiv_pkg::op_divw, 6, 1, 2, '0, '0, 1, 0, 0);
		add_row(muldiv_pkg::op_remuw, 6, 1, 2, '0, '0, 1, 0, 0);
		// flush during a divide, then a multiply
		add_row(muldiv_pkg::op_div, 8, 1, 2, 64'd100, 64'd7, 0, 10, 0);
		add_row(muldiv_pkg::op_mul, 9, 1, 2, 64'd3, 64'd5, 0, 0, 0);
		// results read back from the register file
		add_row(muldiv_pkg::op_mul, 5, 1, 2, 64'd6, 64'd7, 0, 0, 0);
		add_row(muldiv_pkg::op_div, 6, 0, 4, '0, 64'd5, 0, 0, 1);
		add_row(muldiv_pkg::op_rem, 7, 0, 4, '0, 64'd5, 0, 0, 1);
	endtask

	task automatic load_reg(input int idx, input logic [`XLEN-1:0] val);
		load_en = 1'b1;
		load_idx = (`REG_IDX_W)'(idx);
		load_data = val;
		tick();
		load_en = 1'b0;
	endtask

	task automatic drive_issue(input muldiv_pkg::muldiv_op_e op, input int rd, input int rs1,
			input int rs2);
		issue_valid = 1'b1;
		issue_op = op;
		issue_rd = (`REG_IDX_W)'(rd);
		issue_rs1 = (`REG_IDX_W)'(rs1);
		issue_rs2 = (`REG_IDX_W)'(rs2);
	endtask

	task automatic issue_one(input muldiv_pkg::muldiv_op_e op, input int rd, input int rs1,
			input int rs2);
		drive_issue(op, rd, rs1, rs2);
		tick();  // issue edge
		issue_valid = 1'b0;
	endtask

	task automatic wait_ready(output bit ok);
		int n;
		n = 0;
		while (!issue_ready && n < ready_timeout) begin
			tick();
			n++;
		end
		ok = issue_ready;
		if (!ok) begin
			$display("timeout at %0t: issue_ready stayed low for %0d cycles", $time, n);
			n_errors++;
		end
	endtask

	// counts cycles from the issue edge, ready must stay low during a long divide
	task automatic wait_wb(input bit long_op, output int cycles, output bit ok);
		cycles = 0;
		ok = 1'b0;
		while (!ok && cycles < wb_timeout) begin
			tick();
			cycles++;
			ok = wb_valid;
			if (!ok && long_op)
				check_val("issue_ready", '0, (`XLEN)'(issue_ready));
		end
		if (!ok) begin
			$display("timeout at %0t: no writeback within %0d cycles", $time, wb_timeout);
			n_errors++;
		end
	endtask

	task automatic flush_div(input int n);
		bit seen;
		int k;
		seen = 1'b0;
		for (k = 0; k < n; k++) begin
			tick();
			seen |= wb_valid;
		end
		flush = 1'b1;
		tick();
		flush = 1'b0;
		seen |= wb_valid;
		check_val("issue_ready", (`XLEN)'(1), (`XLEN)'(issue_ready));
		for (k = 0; k < flush_watch; k++) begin
			tick();
			seen |= wb_valid;
		end
		check_val("wb_valid", '0, (`XLEN)'(seen));  // abandoned divide stays silent
	endtask

	task automatic run_row(input int i);
		logic [`XLEN-1:0] a;
		logic [`XLEN-1:0] b;
		logic [`XLEN-1:0] exp;
		int rs1;
		int lat;
		int cycles;
		int err_start;
		bit ok;
		err_start = n_errors;
		rs1 = (row_chain[i] != 0) ? prev_rd : row_rs1[i];
		a = row_v1[i];
		b = row_v2[i];
		if (row_rnd[i] != 0) begin
			a = {$urandom(), $urandom()};
			b = {$urandom(), $urandom()};
		end
		if (row_chain[i] != 0)
			a = prev_val;  // rs1 already holds the earlier result
		else
			load_reg(rs1, a);
		load_reg(row_rs2[i], b);
		exp = expect_result(row_op[i], a, b);
		lat = expect_short(row_op[i], a, b) ? 1 : `DIV_STEPS + 1;
		wait_ready(ok);
		if (ok) begin
			issue_one(row_op[i], row_rd[i], rs1, row_rs2[i]);
			check_val("issue_ready", (`XLEN)'(lat == 1), (`XLEN)'(issue_ready));
			if (row_flush[i] != 0) begin
				flush_div(row_flush[i]);
			end else begin
				wait_wb(lat > 1, cycles, ok);
				if (ok) begin
					check_val("wb_valid latency", (`XLEN)'(lat), (`XLEN)'(cycles));
					check_val("wb_data", exp, wb_data);
					check_val("wb_rd", (`XLEN)'(row_rd[i]), (`XLEN)'(wb_rd));
				end
				prev_rd = row_rd[i];
				prev_val = exp;
				tick();  // writeback lands in the register file
			end
		end
		n_tests++;
		$display("test %0d %s %s", i, row_op[i].name(),
			(n_errors == err_start) ? "ok" : "failed");
	endtask

	// three multiplies on consecutive cycles, results on consecutive cycles
	task automatic run_back_to_back();
		muldiv_pkg::muldiv_op_e ops[3];
		logic [`XLEN-1:0] va[3];
		logic [`XLEN-1:0] vb[3];
		int k;
		int err_start;
		bit ok;
		err_start = n_errors;
		ops[0] = muldiv_pkg::op_mul;
		ops[1] = muldiv_pkg::op_mulh;
		ops[2] = muldiv_pkg::op_mulhu;
		for (k = 0; k < 3; k++) begin
			va[k] = {$urandom(), $urandom()};
			vb[k] = {$urandom(), $urandom()};
			load_reg(2*k + 1, va[k]);
			load_reg(2*k + 2, vb[k]);
		end
		wait_ready(ok);
		if (ok) begin
			for (k = 0; k <= 3; k++) begin
				if (k < 3)
					drive_issue(ops[k], 20 + k, 2*k + 1, 2*k + 2);
				else
					issue_valid = 1'b0;
				tick();
				if (k > 0) begin
					check_val("wb_valid", (`XLEN)'(1), (`XLEN)'(wb_valid));
					check_val("wb_rd", (`XLEN)'(20 + k - 1), (`XLEN)'(wb_rd));
					check_val("wb_data", expect_result(ops[k-1], va[k-1], vb[k-1]), wb_data);
				end
			end
			tick();
		end
		n_tests++;
		$display("test back-to-back multiply %s", (n_errors == err_start) ? "ok" : "failed");
	endtask

	initial begin
		int i;
		int err_start;
		rst = 1'b1;
		flush = 1'b0;
		load_en = 1'b0;
		load_idx = '0;
		load_data = '0;
		issue_valid = 1'b0;
		issue_op = muldiv_pkg::op_mul;
		issue_rd = '0;
		issue_rs1 = '0;
		issue_rs2 = '0;
		n_tests = 0;
		n_errors = 0;
		prev_rd = 0;
		prev_val = '0;
		void'($urandom(62));
		build_table();
		repeat (5) @(posedge CLK);
		#1;
		rst = 1'b0;

		err_start = n_errors;
		check_val("wb_valid", '0, (`XLEN)'(wb_valid));
		check_val("wb_data", '0, wb_data);
		check_val("issue_ready", (`XLEN)'(1), (`XLEN)'(issue_ready));
		n_tests++;
		$display("test reset values %s", (n_errors == err_start) ? "ok" : "failed");

		for (i = 0; i < row_op.size(); i++)
			run_row(i);
		run_back_to_back();

		$display("tests %0d, failed checks %0d", n_tests, n_errors);
		if (n_errors == 0)
			$display("** PASS **");
		else
			$display("** FAIL **");
		$finish;
	end

endmodule

//--- src/muldiv_top.sv
/*
 * muldiv_top
 *   register file and multiply/divide execution block
 *   writeback goes to the ports and back into the register file
 */

`timescale 1ns/10ps
`include "muldiv_defines.svh"

module muldiv_top (
	input  logic                   CLK,
	input  logic                   rst,
	input  logic                   flush,
	input  logic                   load_en,
	input  logic [`REG_IDX_W-1:0]  load_idx,
	input  logic [`XLEN-1:0]       load_data,
	input  logic                   issue_valid,
	input  muldiv_pkg::muldiv_op_e issue_op,
	input  logic [`REG_IDX_W-1:0]  issue_rd,
	input  logic [`REG_IDX_W-1:0]  issue_rs1,
	input  logic [`REG_IDX_W-1:0]  issue_rs2,
	output logic                   issue_ready,
	output logic                   wb_valid,
	output logic [`REG_IDX_W-1:0]  wb_rd,
	output logic [`XLEN-1:0]       wb_data
);

	logic [`REG_NUM*`XLEN-1:0] regs_flat;  // all registers, read side

	phys_regfile u_regfile (
		.CLK       (CLK),
		.rst       (rst),
		.load_en   (load_en),
		.load_idx  (load_idx),
		.load_data (load_data),
		.wb_en     (wb_valid),
		.wb_idx    (wb_rd),
		.wb_data   (wb_data),
		.regs_flat (regs_flat)
	);

	muldiv_exe u_exe (
		.CLK         (CLK),
		.rst         (rst),
		.flush       (flush),
		.issue_valid (issue_valid),
		.issue_op    (issue_op),
		.issue_rd    (issue_rd),
		.issue_rs1   (issue_rs1),
		.issue_rs2   (issue_rs2),
		.regs_flat   (regs_flat),
		.issue_ready (issue_ready),
		.wb_valid    (wb_valid),
		.wb_rd       (wb_rd),
		.wb_data     (wb_data)
	);

endmodule

//--- src/phys_regfile.sv
/*
 * phys_regfile
 *   32 x 64 register array, cleared on reset
 *   load port and writeback port, writeback first
 *   flat read bus of all registers
 */

`timescale 1ns/10ps
`include "muldiv_defines.svh"

module phys_regfile (
	input  logic                      CLK,
	input  logic                      rst,
	input  logic                      load_en,
	input  logic [`REG_IDX_W-1:0]     load_idx,
	input  logic [`XLEN-1:0]          load_data,
	input  logic                      wb_en,
	input  logic [`REG_IDX_W-1:0]     wb_idx,
	input  logic [`XLEN-1:0]          wb_data,
	output logic [`REG_NUM*`XLEN-1:0] regs_flat
);

	logic [`XLEN-1:0] regs [`REG_NUM];

	always_ff @(posedge CLK) begin
		if (rst) begin
			for (int i = 0; i < `REG_NUM; i++)
				regs[i] <= '0;
		end else if (wb_en) begin
			regs[wb_idx] <= wb_data;  // unit result beats a load
		end else if (load_en) begin
			regs[load_idx] <= load_data;
		end
	end

	always_comb begin
		for (int i = 0; i < `REG_NUM; i++)
			regs_flat[i*`XLEN +: `XLEN] = regs[i];
	end

	a_wb_idx_range: assert property (@(posedge CLK) disable iff (rst)
		wb_en |-> (wb_idx < `REG_NUM));

endmodule

//--- src/muldiv_exe.sv
/*
 * muldiv_exe
 *   operand fetch from the flat register bus
 *   multiply/divide dispatch, issue stage and writeback registers
 *   issue ready set/reset flop
 */

`timescale 1ns/10ps
`include "muldiv_defines.svh"

module muldiv_exe (
	input  logic                         CLK,
	input  logic                         rst,
	input  logic                         flush,
	input  logic                         issue_valid,
	input  muldiv_pkg::muldiv_op_e       issue_op,
	input  logic [`REG_IDX_W-1:0]        issue_rd,
	input  logic [`REG_IDX_W-1:0]        issue_rs1,
	input  logic [`REG_IDX_W-1:0]        issue_rs2,
	input  logic [`REG_NUM*`XLEN-1:0]    regs_flat,
	output logic                         issue_ready,
	output logic                         wb_valid,
	output logic [`REG_IDX_W-1:0]        wb_rd,
	output logic [`XLEN-1:0]             wb_data
);

	logic [`XLEN-1:0] src1;
	logic [`XLEN-1:0] src2;
	logic [`XLEN-1:0] mul_res;
	logic [`XLEN-1:0] div_res;
	logic is_mul;
	logic is_div;
	logic issue_fire;
	logic div_start;
	logic div_busy;
	logic div_special;
	logic div_done;
	logic iss_valid;
	logic [`XLEN-1:0] iss_data;
	logic [`REG_IDX_W-1:0] iss_rd;
	logic wb_valid_nxt;
	logic [`XLEN-1:0] wb_data_nxt;
	logic [`REG_IDX_W-1:0] wb_rd_nxt;
	logic [`REG_IDX_W-1:0] pend_rd;

	assign src1 = regs_flat[issue_rs1 * `XLEN +: `XLEN];
	assign src2 = regs_flat[issue_rs2 * `XLEN +: `XLEN];

	assign is_mul = issue_op inside {muldiv_pkg::op_mul, muldiv_pkg::op_mulh,
		muldiv_pkg::op_mulhsu, muldiv_pkg::op_mulhu, muldiv_pkg::op_mulw};
	assign is_div = issue_op inside {muldiv_pkg::op_div, muldiv_pkg::op_divu,
		muldiv_pkg::op_rem, muldiv_pkg::op_remu, muldiv_pkg::op_divw,
		muldiv_pkg::op_divuw, muldiv_pkg::op_remw, muldiv_pkg::op_remuw};

	assign issue_fire = issue_valid & issue_ready;
	assign div_start = issue_fire & is_div & ~flush;

	mul_unit u_mul (
		.op      (issue_op),
		.src1    (src1),
		.src2    (src2),
		.product (mul_res)
	);

	div_unit u_div (
		.CLK     (CLK),
		.rst     (rst),
		.flush   (flush),
		.start   (div_start),
		.op      (issue_op),
		.src1    (src1),
		.src2    (src2),
		.busy    (div_busy),
		.special (div_special),
		.done    (div_done),
		.result  (div_res)
	);

	// multiply and special divide results wait here for one cycle
	always_ff @(posedge CLK) begin
		if (rst)
			iss_valid <= 1'b0;
		else
			iss_valid <= ~flush & ((issue_fire & is_mul) | div_special);
	end

	always_ff @(posedge CLK) begin
		if (issue_fire) begin
			iss_data <= div_special ? div_res : mul_res;
			iss_rd <= issue_rd;
		end
	end

	// issue side results and the divider never collide, ready is low while busy
	assign wb_valid_nxt = ~flush & (iss_valid | div_done);
	assign wb_data_nxt = div_done ? div_res : iss_data;
	assign wb_rd_nxt = div_done ? pend_rd : iss_rd;

	always_ff @(posedge CLK) begin
		if (div_start && !div_special)
			pend_rd <= issue_rd;  // rd of the running divide
	end

	always_ff @(posedge CLK) begin
		if (rst) begin
			wb_valid <= 1'b0;
			wb_data <= '0;
			wb_rd <= '0;
		end else begin
			wb_valid <= wb_valid_nxt;
			if (wb_valid_nxt) begin
				wb_data <= wb_data_nxt;
				wb_rd <= wb_rd_nxt;
			end
		end
	end

	always_ff @(posedge CLK) begin
		if (rst)
			issue_ready <= 1'b1;
		else if (div_done || flush)
			issue_ready <= 1'b1;  // set wins
		else if (div_start && !div_special)
			issue_ready <= 1'b0;  // long divide in flight
	end

	a_ready_low_busy: assert property (@(posedge CLK) disable iff (rst)
		(!issue_ready && $past(!issue_ready)) |-> (div_busy && !wb_valid));

endmodule

//--- src/div_unit.sv
/*
 * div_unit
 *   iterative restoring divider for DIV/DIVU/REM/REMU and W forms
 *   special results for divide-by-zero and signed overflow
 *   sign fix-up of quotient and remainder, W sign extension
 */

`timescale 1ns/10ps
`include "muldiv_defines.svh"

module div_unit (
	input  logic                   CLK,
	input  logic                   rst,
	input  logic                   flush,
	input  logic                   start,
	input  muldiv_pkg::muldiv_op_e op,
	input  logic [`XLEN-1:0]       src1,
	input  logic [`XLEN-1:0]       src2,
	output logic                   busy,
	output logic                   special,
	output logic                   done,
	output logic [`XLEN-1:0]       result
);

	localparam logic [`DIV_CNT_W-1:0] cnt_last = (`DIV_CNT_W)'(`DIV_STEPS);

	logic in_w;
	logic in_uns;
	logic in_rem;
	logic a_neg;
	logic b_neg;
	logic div_zero;
	logic overflow;
	logic [`XLEN-1:0] a_sx_w;
	logic [`XLEN-1:0] a_ext;
	logic [`XLEN-1:0] b_ext;
	logic [`XLEN-1:0] a_mag;
	logic [`XLEN-1:0] b_mag;
	logic [`XLEN-1:0] special_res;

	logic [`DIV_CNT_W-1:0] cnt;
	muldiv_pkg::muldiv_op_e op_q;
	logic neg_q;
	logic neg_r;
	logic [2*`XLEN-1:0] acc;  // {remainder, quotient}
	logic [`XLEN-1:0] dsor;
	logic [`XLEN:0] part;
	logic [`XLEN:0] diff;
	logic take;
	logic [2*`XLEN-1:0] acc_step;
	logic q_w;
	logic q_rem;
	logic [`XLEN-1:0] q_fix;
	logic [`XLEN-1:0] r_fix;
	logic [`XLEN-1:0] loop_res;
	logic [`XLEN-1:0] final_res;

	assign in_w = op inside {muldiv_pkg::op_divw, muldiv_pkg::op_divuw,
		muldiv_pkg::op_remw, muldiv_pkg::op_remuw};
	assign in_uns = op inside {muldiv_pkg::op_divu, muldiv_pkg::op_remu,
		muldiv_pkg::op_divuw, muldiv_pkg::op_remuw};
	assign in_rem = op inside {muldiv_pkg::op_rem, muldiv_pkg::op_remu,
		muldiv_pkg::op_remw, muldiv_pkg::op_remuw};

	assign a_sx_w = {{(`XLEN-32){src1[31]}}, src1[31:0]};
	assign a_neg = ~in_uns & (in_w ? src1[31] : src1[`XLEN-1]);
	assign b_neg = ~in_uns & (in_w ? src2[31] : src2[`XLEN-1]);
	assign a_ext = ~in_w ? src1 : (in_uns ? {{(`XLEN-32){1'b0}}, src1[31:0]} : a_sx_w);
	assign b_ext = ~in_w ? src2
		: (in_uns ? {{(`XLEN-32){1'b0}}, src2[31:0]} : {{(`XLEN-32){src2[31]}}, src2[31:0]});
	assign a_mag = a_neg ? -a_ext : a_ext;
	assign b_mag = b_neg ? -b_ext : b_ext;

	// special cases at the selected width
	assign div_zero = in_w ? (src2[31:0] == 32'd0) : (src2 == '0);
	assign overflow = ~in_uns & (in_w
		? ((src1[31:0] == 32'h8000_0000) & (&src2[31:0]))
		: ((src1 == {1'b1, {(`XLEN-1){1'b0}}}) & (&src2)));
	assign special = start & (div_zero | overflow);

	always_comb begin
		if (div_zero)
			special_res = in_rem ? (in_w ? a_sx_w : src1) : '1;
		else
			special_res = in_rem ? '0 : a_ext;  // overflow quotient is the minimum value
	end

	// one restoring step
	assign part = acc[2*`XLEN-1:`XLEN-1];
	assign diff = part - {1'b0, dsor};
	assign take = (part >= {1'b0, dsor});
	assign acc_step = take ? {diff[`XLEN-1:0], acc[`XLEN-2:0], 1'b1}
		: {acc[2*`XLEN-2:0], 1'b0};

	always_ff @(posedge CLK) begin
		if (rst || flush) begin
			busy <= 1'b0;  // flush abandons a running divide
			cnt <= '0;
		end else if (start && !special) begin
			busy <= 1'b1;
			cnt <= '0;
		end else if (busy) begin
			if (cnt == cnt_last)
				busy <= 1'b0;
			else
				cnt <= cnt + (`DIV_CNT_W)'(1);
		end
	end

	always_ff @(posedge CLK) begin
		if (start && !special) begin
			acc <= {{`XLEN{1'b0}}, a_mag};
			dsor <= b_mag;
			neg_q <= a_neg ^ b_neg;
			neg_r <= a_neg;  // remainder follows the dividend
			op_q <= op;
		end else if (busy && cnt != cnt_last) begin
			acc <= acc_step;
		end
	end

	assign q_w = op_q inside {muldiv_pkg::op_divw, muldiv_pkg::op_divuw,
		muldiv_pkg::op_remw, muldiv_pkg::op_remuw};
	assign q_rem = op_q inside {muldiv_pkg::op_rem, muldiv_pkg::op_remu,
		muldiv_pkg::op_remw, muldiv_pkg::op_remuw};

	assign q_fix = neg_q ? -acc[`XLEN-1:0] : acc[`XLEN-1:0];
	assign r_fix = neg_r ? -acc[2*`XLEN-1:`XLEN] : acc[2*`XLEN-1:`XLEN];
	assign loop_res = q_rem ? r_fix : q_fix;
	assign final_res = q_w ? {{(`XLEN-32){loop_res[31]}}, loop_res[31:0]} : loop_res;

	assign done = busy & (cnt == cnt_last);
	assign result = special ? special_res : final_res;

	a_no_start_busy: assert property (@(posedge CLK) disable iff (rst)
		start |-> !busy);

	// issue edge, DIV_STEPS step edges, then done is seen
	a_div_latency: assert property (@(posedge CLK) disable iff (rst || flush)
		(start && !special) |-> ##(`DIV_STEPS + 1) done);

endmodule

//--- src/mul_unit.sv
/*
 * mul_unit
 *   combinational RV64M multiplier, 65x65 signed product
 *   operand sign and width preparation, result slicing
 */

`timescale 1ns/10ps
`include "muldiv_defines.svh"

module mul_unit (
	input  muldiv_pkg::muldiv_op_e op,
	input  logic [`XLEN-1:0]       src1,
	input  logic [`XLEN-1:0]       src2,
	output logic [`XLEN-1:0]       product
);

	logic w_form;
	logic s1_signed;
	logic s2_signed;
	logic [`XLEN:0] opa;
	logic [`XLEN:0] opb;
	logic signed [2*`XLEN-1:0] prod;

	assign w_form = (op == muldiv_pkg::op_mulw);
	assign s1_signed = op inside {muldiv_pkg::op_mul, muldiv_pkg::op_mulh,
		muldiv_pkg::op_mulhsu, muldiv_pkg::op_mulw};
	assign s2_signed = op inside {muldiv_pkg::op_mul, muldiv_pkg::op_mulh,
		muldiv_pkg::op_mulw};

	// extra top bit turns unsigned operands into positive signed ones
	assign opa = w_form ? {{(`XLEN-31){src1[31]}}, src1[31:0]}
		: {s1_signed & src1[`XLEN-1], src1};
	assign opb = w_form ? {{(`XLEN-31){src2[31]}}, src2[31:0]}
		: {s2_signed & src2[`XLEN-1], src2};

	assign prod = $signed({{(`XLEN-1){opa[`XLEN]}}, opa})
		* $signed({{(`XLEN-1){opb[`XLEN]}}, opb});  // low 128 bits are exact

	always_comb begin
		case (op)
			muldiv_pkg::op_mul:    product = prod[`XLEN-1:0];
			muldiv_pkg::op_mulh,
			muldiv_pkg::op_mulhsu,
			muldiv_pkg::op_mulhu:  product = prod[2*`XLEN-1:`XLEN];  // upper half
			muldiv_pkg::op_mulw:   product = {{(`XLEN-32){prod[31]}}, prod[31:0]};
			default:               product = '0;  // divide ops, result from divider
		endcase
	end

endmodule

//--- src/muldiv_pkg.sv
/*
 * shared types of the M-extension unit
 *   muldiv_op_e, the thirteen RV64M operations
 */

package muldiv_pkg;

	typedef enum logic [3:0] {
		op_mul    = 4'd0,  // low 64 bits, signed x signed
		op_mulh   = 4'd1,  // high 64 bits, signed x signed
		op_mulhsu = 4'd2,  // high 64 bits, signed x unsigned
		op_mulhu  = 4'd3,  // high 64 bits, unsigned x unsigned
		op_div    = 4'd4,
		op_divu   = 4'd5,
		op_rem    = 4'd6,
		op_remu   = 4'd7,
		op_mulw   = 4'd8,  // 32-bit forms, result sign-extended
		op_divw   = 4'd9,
		op_divuw  = 4'd10,
		op_remw   = 4'd11,
		op_remuw  = 4'd12
	} muldiv_op_e;

endpackage

//--- src/muldiv_defines.svh
/*
 * width and count macros for the M-extension unit
 *   data width, register count and index width
 *   divider step count and counter width
 */

`ifndef MULDIV_DEFINES_SVH
`define MULDIV_DEFINES_SVH

// datapath
`define XLEN 64

// register file
`define REG_NUM 32
`define REG_IDX_W 5

// restoring divider, one quotient bit per step
`define DIV_STEPS 64
`define DIV_CNT_W 7

`endif
